// File: exec_pipe.f
+incdir+src
src/cpu_types_pkg.sv
src/ex_mem_reg_if.sv
src/exec_alu.sv
src/pipe_control.sv
src/ex_mem_reg.sv
src/data_mem.sv
src/mem_wb_reg.sv
src/exec_pipe.sv
tests/exec_pipe_asserts.sv
tests/exec_pipe_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the exec_pipe testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f exec_pipe.f \
	--top-module exec_pipe_tb -o exec_pipe_sim

./obj_dir/exec_pipe_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1

// File: tests/exec_pipe_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for exec_pipe. Inputs change on the falling edge, and every
// writeback is compared with the oldest predicted one in its due cycle.
// Stimulus comes from a Galois LFSR with a fixed seed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cpu_cfg.svh"

module exec_pipe_tb import cpu_types_pkg::*; ();

	typedef logic [`DMEM_AW-1:0] waddr_t;

	logic        CLK;
	logic        nRST;
	logic [31:0] instr;
	logic [31:0] rdat1;
	logic [31:0] rdat2;
	logic        issue;
	logic        stall;
	logic        kill;
	logic        wb_wen;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	logic        halted;

	logic [31:0] lfsr = 32'd5;
	int          cyc = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests_failed = 0;
	logic [4:0]  exp_reg [$];
	logic [31:0] exp_data [$];
	int          exp_due [$];
	logic [31:0] shadow [`DMEM_WORDS];

	exec_pipe i_exec_pipe (.*);

	bind exec_pipe exec_pipe_asserts i_exec_pipe_asserts (
		.CLK    (CLK),
		.nRST   (nRST),
		.issue  (issue),
		.stall  (stall),
		.kill   (kill),
		.wb_wen (wb_wen),
		.wb_reg (wb_reg),
		.halted (halted)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) cyc <= cyc + 1;

	// one LFSR step per bit with the taps of x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [4:0] r;
		r = 5'(rand_bits(5));
		return (r == 5'd0) ? 5'd31 : r;
	endfunction

	function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] sh);
		return {OP_RTYPE, 10'd0, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rt,
		input logic [15:0] imm);
		return {op, 5'd0, rt, imm};
	endfunction

	// expected R-type value with the register operand as operand B.
	function automatic logic [31:0] r_result(input logic [5:0] fn, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] sh);
		case (fn)
			FN_ADD:  return a + b;
			FN_SUB:  return a - b;
			FN_AND:  return a & b;
			FN_OR:   return a | b;
			FN_XOR:  return a ^ b;
			FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			FN_SLL:  return b << sh;
			default: return 32'd0;
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] expv,
		input logic [31:0] got);
		checks++;
		assert (got === expv) else begin
			$display("CHECK FAILED %s expected %h got %h", name, expv, got);
			errors++;
		end
	endtask

	// failures of the immediate checks and of the bound assertions together.
	function automatic int error_count();
		return errors + i_exec_pipe.i_exec_pipe_asserts.fails;
	endfunction

	// a destination of 0 means that no writeback is expected.
	task automatic issue_op(input logic [31:0] word, input logic [31:0] a,
		input logic [31:0] b, input logic [4:0] dst, input logic [31:0] val,
		input int stalls, input logic drop);
		instr = word;
		rdat1 = a;
		rdat2 = b;
		issue = 1'b1;
		kill = drop;
		if (dst != 5'd0 && !drop) begin
			exp_reg.push_back(dst);
			exp_data.push_back(val);
			exp_due.push_back(cyc + 2 + stalls);
		end
		@(negedge CLK);
		issue = 1'b0;
		kill = 1'b0;
		if (stalls > 0) begin
			stall = 1'b1;
			repeat (stalls) @(negedge CLK);
			stall = 1'b0;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		int n;
		n = 0;
		while (exp_due.size() > 0 && n < 40) begin
			@(negedge CLK);
			n++;
		end
		if (exp_due.size() > 0) begin
			$display("timeout, %0d writebacks never arrived", exp_due.size());
			errors++;
			exp_reg.delete();
			exp_data.delete();
			exp_due.delete();
		end
		repeat (3) @(negedge CLK);
		if (error_count() == errs_before) begin
			$display("test %s ok", name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, error_count() - errs_before);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// writeback monitor.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(negedge CLK) begin
		if (nRST && wb_wen) begin
			assert (exp_due.size() > 0) else begin
				$display("unexpected writeback to r%0d in cycle %0d", wb_reg, cyc);
				errors++;
			end
			if (exp_due.size() > 0) begin
				check_val("wb_cycle", exp_due[0], cyc);
				check_val("wb_reg", 32'(exp_reg[0]), 32'(wb_reg));
				check_val("wb_data", exp_data[0], wb_data);
				void'(exp_reg.pop_front());
				void'(exp_data.pop_front());
				void'(exp_due.pop_front());
			end
		end else if (exp_due.size() > 0) begin
			assert (exp_due[0] > cyc) else begin
				$display("writeback to r%0d missing in cycle %0d", exp_reg[0], cyc);
				errors++;
				void'(exp_reg.pop_front());
				void'(exp_data.pop_front());
				void'(exp_due.pop_front());
			end
		end
	end

	initial begin
		int          e;
		int          n;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] base;
		logic [4:0]  rd;
		logic [4:0]  sh;
		logic [15:0] imm;
		logic [5:0]  fns [7];
		waddr_t      wa [4];

		nRST = 1'b0;
		instr = '0;
		rdat1 = '0;
		rdat2 = '0;
		issue = 1'b0;
		stall = 1'b0;
		kill = 1'b0;
		foreach (shadow[k]) shadow[k] = '0;
		fns = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL};

		e = error_count();
		for (int k = 0; k < 24; k++) begin
			@(negedge CLK);
			if (k == 15) nRST = 1'b1;
			check_val("wb_wen", 32'd0, 32'(wb_wen));
			check_val("halted", 32'd0, 32'(halted));
		end
		end_test("reset_idle", e);

		e = error_count();
		foreach (fns[k]) begin
			a = rand_bits(32);
			b = rand_bits(32);
			sh = 5'(rand_bits(5));
			rd = pick_reg();
			issue_op(r_word(fns[k], rd, sh), a, b, rd, r_result(fns[k], a, b, sh), 0, 1'b0);
		end
		a = rand_bits(32);
		issue_op(r_word(FN_ADD, 5'd0, 5'd0), a, a, 5'd0, 32'd0, 0, 1'b0);
		end_test("rtype", e);

		// immediates keep bit 15 set so that the extension mode shows.
		e = error_count();
		a = rand_bits(32);
		imm = {1'b1, 15'(rand_bits(15))};
		rd = pick_reg();
		issue_op(i_word(OP_ADDI, rd, imm), a, 32'd0, rd, a + {{16{imm[15]}}, imm}, 0, 1'b0);
		rd = pick_reg();
		issue_op(i_word(OP_ANDI, rd, imm), a, 32'd0, rd, a & {16'h0000, imm}, 0, 1'b0);
		rd = pick_reg();
		issue_op(i_word(OP_ORI, rd, imm), a, 32'd0, rd, a | {16'h0000, imm}, 0, 1'b0);
		rd = pick_reg();
		issue_op(i_word(OP_LUI, rd, imm), a, 32'd0, rd, {imm, 16'h0000}, 0, 1'b0);
		end_test("itype", e);

		// the base keeps the low address bits clear and its upper bits wrap away.
		e = error_count();
		for (int k = 0; k < 4; k++) begin
			wa[k] = waddr_t'(rand_bits(`DMEM_AW));
			b = rand_bits(32);
			base = rand_bits(32) & ~32'(`DMEM_WORDS * 4 - 1);
			imm = 16'({wa[k], 2'b00});
			shadow[wa[k]] = b;
			rd = pick_reg();
			issue_op(i_word(OP_SW, rd, imm), base, b, 5'd0, 32'd0, 0, 1'b0);
		end
		for (int k = 0; k < 4; k++) begin
			base = rand_bits(32) & ~32'(`DMEM_WORDS * 4 - 1);
			imm = 16'({wa[k], 2'b00});
			rd = pick_reg();
			issue_op(i_word(OP_LW, rd, imm), base, 32'd0, rd, shadow[wa[k]], 0, 1'b0);
		end
		end_test("memory", e);

		e = error_count();
		for (int k = 0; k < 3; k++) begin
			a = rand_bits(32);
			b = rand_bits(32);
			rd = pick_reg();
			n = 1 + int'(rand_bits(3));
			issue_op(r_word(FN_SUB, rd, 5'd0), a, b, rd, a - b, n, 1'b0);
			rd = pick_reg();
			issue_op(r_word(FN_ADD, rd, 5'd0), a, b, rd, a + b, 0, 1'b1);
		end
		end_test("stall_kill", e);

		// after halted no issue may reach writeback.
		e = error_count();
		issue_op({OP_HALT, 26'd0}, 32'd0, 32'd0, 5'd0, 32'd0, 0, 1'b0);
		n = 0;
		while (!halted && n < 10) begin
			@(negedge CLK);
			n++;
		end
		assert (halted) else begin
			$display("halted was never set after the halt instruction");
			errors++;
		end
		for (int k = 0; k < 4; k++) begin
			a = rand_bits(32);
			rd = pick_reg();
			issue_op(r_word(FN_ADD, rd, 5'd0), a, a, 5'd0, 32'd0, 0, 1'b0);
		end
		check_val("halted", 32'd1, 32'(halted));
		end_test("halt", e);

		$display("6 tests, %0d failed, %0d checks, %0d errors", tests_failed, checks,
			error_count());
		if (error_count() == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: tests/exec_pipe_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cycle rules of the exec_pipe ports for a bind into the top level.
// Only the top-level ports are observed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module exec_pipe_asserts (
	input logic       CLK,
	input logic       nRST,
	input logic       issue,
	input logic       stall,
	input logic       kill,
	input logic       wb_wen,
	input logic [4:0] wb_reg,
	input logic       halted
);

	int fails = 0;

	// reset clears the writeback strobe and the halt flag.
	reset_quiet: assert property (@(posedge CLK) !nRST |-> !wb_wen && !halted)
		else begin
			$error("wb_wen or halted high during reset");
			fails++;
		end

	// a stall blocks the commit, so MEM/WB takes a bubble.
	stall_no_wb: assert property (@(posedge CLK) disable iff (!nRST)
		stall |=> !wb_wen)
		else begin
			$error("writeback in the cycle after a stall");
			fails++;
		end

	// an unstalled empty slot leaves EX/MEM as a bubble and reaches writeback
	// two edges later.
	idle_no_wb: assert property (@(posedge CLK) disable iff (!nRST)
		!issue && !stall |-> ##2 !wb_wen)
		else begin
			$error("writeback from an idle issue slot");
			fails++;
		end

	kill_no_wb: assert property (@(posedge CLK) disable iff (!nRST)
		issue && kill && !stall |-> ##2 !wb_wen)
		else begin
			$error("writeback from a killed instruction");
			fails++;
		end

	halt_no_wb: assert property (@(posedge CLK) disable iff (!nRST)
		halted && !stall |-> ##2 !wb_wen)
		else begin
			$error("writeback after the pipeline halted");
			fails++;
		end

	// halted only clears on reset.
	halt_sticky: assert property (@(posedge CLK) disable iff (!nRST)
		halted |=> halted)
		else begin
			$error("halted cleared without reset");
			fails++;
		end

	no_r0_write: assert property (@(posedge CLK) disable iff (!nRST)
		wb_wen |-> wb_reg != 5'd0)
		else begin
			$error("writeback to register 0");
			fails++;
		end

endmodule

// File: src/exec_pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute to writeback top level. Writeback follows issue by two
// cycles plus one per stall cycle. No forwarding between instructions.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module exec_pipe (
	input  logic        CLK,
	input  logic        nRST,
	input  logic [31:0] instr,
	input  logic [31:0] rdat1,
	input  logic [31:0] rdat2,
	input  logic        issue,
	input  logic        stall,
	input  logic        kill,
	output logic        wb_wen,
	output logic [4:0]  wb_reg,
	output logic [31:0] wb_data,
	output logic        halted
);

	logic        alu_src;
	logic        zero_ext;
	logic        wb_halt;
	logic [31:0] mem_rdata;

	ex_mem_reg_if ex_mem_regif ();

	pipe_control i_pipe_control (
		.CLK          (CLK),
		.nRST         (nRST),
		.instr        (instr),
		.issue        (issue),
		.stall        (stall),
		.kill         (kill),
		.wb_halt      (wb_halt),
		.halted       (halted),
		.alu_src      (alu_src),
		.zero_ext     (zero_ext),
		.ex_mem_regif (ex_mem_regif.ctl)
	);

	exec_alu i_exec_alu (
		.ex_mem_regif (ex_mem_regif.alu),
		.rdat1        (rdat1),
		.rdat2_in     (rdat2),
		.instr        (instr),
		.alu_src      (alu_src),
		.zero_ext     (zero_ext)
	);

	ex_mem_reg i_ex_mem_reg (
		.CLK          (CLK),
		.nRST         (nRST),
		.ex_mem_regif (ex_mem_regif.regs)
	);

	data_mem i_data_mem (
		.CLK          (CLK),
		.nRST         (nRST),
		.ex_mem_regif (ex_mem_regif.mem),
		.rdata        (mem_rdata)
	);

	mem_wb_reg i_mem_wb_reg (
		.CLK          (CLK),
		.nRST         (nRST),
		.ex_mem_regif (ex_mem_regif.mem),
		.rdata        (mem_rdata),
		.wb_wen       (wb_wen),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data),
		.wb_halt      (wb_halt)
	);

endmodule

// File: src/mem_wb_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MEM/WB register driving the writeback ports. Writes to register 0
// are dropped. wb_reg and wb_data are valid only with wb_wen.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_wb_reg import cpu_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	ex_mem_reg_if.mem ex_mem_regif,
	input  word_t     rdata,
	output logic      wb_wen,
	output regbits_t  wb_reg,
	output word_t     wb_data,
	output logic      wb_halt
);

	regbits_t dest;
	logic     wen_nxt;

	assign dest = (ex_mem_regif.reg_dest_EX_MEM == SEL_RT) ? ex_mem_regif.Rt_EX_MEM
		: ex_mem_regif.Rd_EX_MEM;

	// without a commit this stage takes a bubble.
	assign wen_nxt = ex_mem_regif.mem_commit & ex_mem_regif.WEN_EX_MEM & (dest != '0);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_wen <= 1'b0;
			wb_halt <= 1'b0;
		end else begin
			wb_wen <= wen_nxt;
			wb_halt <= ex_mem_regif.mem_commit & ex_mem_regif.halt_EX_MEM;
		end
	end

	always_ff @(posedge CLK) begin
		wb_reg <= dest;
		if (ex_mem_regif.dmemREN) begin
			wb_data <= rdata;
		end else begin
			wb_data <= ex_mem_regif.result_EX_MEM;
		end
	end

endmodule

// File: src/data_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word-addressed data memory, combinational read and clocked write.
// Byte address bits 1:0 are ignored and upper bits wrap.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cpu_cfg.svh"

module data_mem import cpu_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	ex_mem_reg_if.mem ex_mem_regif,
	output word_t     rdata
);

	word_t                 mem [`DMEM_WORDS];
	logic [`DMEM_AW-1:0] waddr;

	assign waddr = ex_mem_regif.dmemaddr_EX_MEM[`DMEM_AW+1:2];
	assign rdata = mem[waddr];

	// a stalled store waits for mem_commit so it writes once.
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mem <= '{default: '0};
		end else if (ex_mem_regif.dmemWEN && ex_mem_regif.mem_commit) begin
			mem[waddr] <= ex_mem_regif.dmemstore_EX_MEM;
		end
	end

endmodule

// File: src/ex_mem_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// EX/MEM pipeline register. Flush wins over enable; with neither the
// register holds. Reset and flush both leave a bubble.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ex_mem_reg import cpu_types_pkg::*; (
	input  logic       CLK,
	input  logic       nRST,
	ex_mem_reg_if.regs ex_mem_regif
);

	logic                  wen_reg, wen_nxt;
	logic                  dren_reg, dren_nxt;
	logic                  dwen_reg, dwen_nxt;
	logic                  halt_reg, halt_nxt;
	reg_dest_mux_selection reg_dest_reg, reg_dest_nxt;
	regbits_t              rt_reg, rt_nxt;
	regbits_t              rd_reg, rd_nxt;
	word_t                 result_reg, result_nxt;
	word_t                 rdat2_reg, rdat2_nxt;

	// the memory address and the writeback value are the same ALU result.
	assign ex_mem_regif.dmemaddr_EX_MEM = result_reg;
	assign ex_mem_regif.result_EX_MEM = result_reg;
	assign ex_mem_regif.dmemstore_EX_MEM = rdat2_reg;
	assign ex_mem_regif.WEN_EX_MEM = wen_reg;
	assign ex_mem_regif.reg_dest_EX_MEM = reg_dest_reg;
	assign ex_mem_regif.Rt_EX_MEM = rt_reg;
	assign ex_mem_regif.Rd_EX_MEM = rd_reg;
	assign ex_mem_regif.dmemREN = dren_reg;
	assign ex_mem_regif.dmemWEN = dwen_reg;
	assign ex_mem_regif.halt_EX_MEM = halt_reg;

	always_comb begin
		// hold by default.
		wen_nxt = wen_reg;
		dren_nxt = dren_reg;
		dwen_nxt = dwen_reg;
		halt_nxt = halt_reg;
		reg_dest_nxt = reg_dest_reg;
		rt_nxt = rt_reg;
		rd_nxt = rd_reg;
		result_nxt = result_reg;
		rdat2_nxt = rdat2_reg;

		if (ex_mem_regif.flush_EX_MEM) begin
			wen_nxt = 1'b0;
			dren_nxt = 1'b0;
			dwen_nxt = 1'b0;
			halt_nxt = 1'b0;
			reg_dest_nxt = SEL_RD;
			rt_nxt = '0;
			rd_nxt = '0;
			result_nxt = '0;
			rdat2_nxt = '0;
		end else if (ex_mem_regif.enable_EX_MEM) begin
			wen_nxt = ex_mem_regif.WEN_ID_EX;
			dren_nxt = ex_mem_regif.dREN_ID_EX;
			dwen_nxt = ex_mem_regif.dWEN_ID_EX;
			halt_nxt = ex_mem_regif.halt_ID_EX;
			reg_dest_nxt = ex_mem_regif.reg_dest_ID_EX;
			rt_nxt = ex_mem_regif.Rt_ID_EX;
			rd_nxt = ex_mem_regif.Rd_ID_EX;
			result_nxt = ex_mem_regif.result;
			rdat2_nxt = ex_mem_regif.rdat2;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wen_reg <= 1'b0;
			dren_reg <= 1'b0;
			dwen_reg <= 1'b0;
			halt_reg <= 1'b0;
			reg_dest_reg <= SEL_RD;
			rt_reg <= '0;
			rd_reg <= '0;
			result_reg <= '0;
			rdat2_reg <= '0;
		end else begin
			wen_reg <= wen_nxt;
			dren_reg <= dren_nxt;
			dwen_reg <= dwen_nxt;
			halt_reg <= halt_nxt;
			reg_dest_reg <= reg_dest_nxt;
			rt_reg <= rt_nxt;
			rd_reg <= rd_nxt;
			result_reg <= result_nxt;
			rdat2_reg <= rdat2_nxt;
		end
	end

endmodule

// File: src/pipe_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decode and EX/MEM control. Unknown encodings become a
// no-write bubble. halted is sticky until reset.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module pipe_control import cpu_types_pkg::*; (
	input  logic      CLK,
	input  logic      nRST,
	input  instr_u    instr,
	input  logic      issue,
	input  logic      stall,
	input  logic      kill,
	input  logic      wb_halt,
	output logic      halted,
	output logic      alu_src,
	output logic      zero_ext,
	ex_mem_reg_if.ctl ex_mem_regif
);

	// register fields are taken straight from the word.
	assign ex_mem_regif.Rt_ID_EX = instr.i.rt;
	assign ex_mem_regif.Rd_ID_EX = instr.r.rd;

	always_comb begin
		ex_mem_regif.alu_op_ID_EX = ALU_ADD;
		ex_mem_regif.reg_dest_ID_EX = SEL_RT;
		ex_mem_regif.WEN_ID_EX = 1'b0;
		ex_mem_regif.dREN_ID_EX = 1'b0;
		ex_mem_regif.dWEN_ID_EX = 1'b0;
		ex_mem_regif.halt_ID_EX = 1'b0;
		alu_src = 1'b1;
		zero_ext = 1'b0;

		case (instr.r.opcode)
			OP_RTYPE: begin
				ex_mem_regif.reg_dest_ID_EX = SEL_RD;
				ex_mem_regif.WEN_ID_EX = 1'b1;
				alu_src = 1'b0;
				case (instr.r.funct)
					FN_ADD:  ex_mem_regif.alu_op_ID_EX = ALU_ADD;
					FN_SUB:  ex_mem_regif.alu_op_ID_EX = ALU_SUB;
					FN_AND:  ex_mem_regif.alu_op_ID_EX = ALU_AND;
					FN_OR:   ex_mem_regif.alu_op_ID_EX = ALU_OR;
					FN_XOR:  ex_mem_regif.alu_op_ID_EX = ALU_XOR;
					FN_SLT:  ex_mem_regif.alu_op_ID_EX = ALU_SLT;
					FN_SLL:  ex_mem_regif.alu_op_ID_EX = ALU_SLL;
					default: ex_mem_regif.WEN_ID_EX = 1'b0;
				endcase
			end
			OP_ADDI: ex_mem_regif.WEN_ID_EX = 1'b1;
			OP_ANDI: begin
				ex_mem_regif.alu_op_ID_EX = ALU_AND;
				ex_mem_regif.WEN_ID_EX = 1'b1;
				zero_ext = 1'b1;
			end
			OP_ORI: begin
				ex_mem_regif.alu_op_ID_EX = ALU_OR;
				ex_mem_regif.WEN_ID_EX = 1'b1;
				zero_ext = 1'b1;
			end
			OP_LUI: begin
				ex_mem_regif.alu_op_ID_EX = ALU_LUI;
				ex_mem_regif.WEN_ID_EX = 1'b1;
			end
			OP_LW: begin
				ex_mem_regif.WEN_ID_EX = 1'b1;
				ex_mem_regif.dREN_ID_EX = 1'b1;
			end
			OP_SW:   ex_mem_regif.dWEN_ID_EX = 1'b1;
			OP_HALT: ex_mem_regif.halt_ID_EX = 1'b1;
			default: ex_mem_regif.WEN_ID_EX = 1'b0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pipeline control.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a stall holds EX/MEM and blocks the commit, so flush only acts unstalled.
	assign ex_mem_regif.enable_EX_MEM = ~stall;
	assign ex_mem_regif.flush_EX_MEM = ~stall & (~issue | kill | halted);
	assign ex_mem_regif.mem_commit = ~stall;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			halted <= 1'b0;
		end else if (wb_halt) begin
			halted <= 1'b1;
		end
	end

endmodule

// File: src/exec_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational execute stage. No overflow trap on ADD or SUB.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module exec_alu import cpu_types_pkg::*; (
	ex_mem_reg_if.alu ex_mem_regif,
	input  word_t     rdat1,
	input  word_t     rdat2_in,
	input  instr_u    instr,
	input  logic      alu_src,
	input  logic      zero_ext
);

	word_t imm_ext;
	word_t opb;

	// immediates are sign extended except for the logical I-type ops.
	assign imm_ext = zero_ext ? {16'h0000, instr.i.imm}
		: {{16{instr.i.imm[15]}}, instr.i.imm};

	assign opb = alu_src ? imm_ext : rdat2_in;

	always_comb begin
		case (ex_mem_regif.alu_op_ID_EX)
			ALU_ADD: ex_mem_regif.result = rdat1 + opb;
			ALU_SUB: ex_mem_regif.result = rdat1 - opb;
			ALU_AND: ex_mem_regif.result = rdat1 & opb;
			ALU_OR:  ex_mem_regif.result = rdat1 | opb;
			ALU_XOR: ex_mem_regif.result = rdat1 ^ opb;
			ALU_SLT: ex_mem_regif.result = {31'd0, $signed(rdat1) < $signed(opb)};
			// the shift amount comes from the instruction, not a register.
			ALU_SLL: ex_mem_regif.result = opb << instr.r.shamt;
			ALU_LUI: ex_mem_regif.result = {instr.i.imm, 16'h0000};
			default: ex_mem_regif.result = '0;
		endcase
	end

	// the second operand is the store data for SW.
	assign ex_mem_regif.rdat2 = rdat2_in;

endmodule

// File: src/ex_mem_reg_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ID/EX fields into the EX/MEM register and EX/MEM fields out of it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface ex_mem_reg_if import cpu_types_pkg::*; ();

	// decoded ID/EX side and pipeline control.
	logic                  WEN_ID_EX;
	reg_dest_mux_selection reg_dest_ID_EX;
	aluop_t                alu_op_ID_EX;
	regbits_t              Rt_ID_EX;
	regbits_t              Rd_ID_EX;
	logic                  dREN_ID_EX;
	logic                  dWEN_ID_EX;
	logic                  halt_ID_EX;
	logic                  enable_EX_MEM;
	logic                  flush_EX_MEM;
	logic                  mem_commit;

	// execute results.
	word_t result;
	word_t rdat2;

	// latched EX/MEM side.
	word_t                 dmemaddr_EX_MEM;
	word_t                 dmemstore_EX_MEM;
	word_t                 result_EX_MEM;
	logic                  WEN_EX_MEM;
	reg_dest_mux_selection reg_dest_EX_MEM;
	regbits_t              Rt_EX_MEM;
	regbits_t              Rd_EX_MEM;
	logic                  dmemREN;
	logic                  dmemWEN;
	logic                  halt_EX_MEM;

	modport ctl (
		output WEN_ID_EX, reg_dest_ID_EX, alu_op_ID_EX, Rt_ID_EX, Rd_ID_EX,
		output dREN_ID_EX, dWEN_ID_EX, halt_ID_EX,
		output enable_EX_MEM, flush_EX_MEM, mem_commit
	);

	modport alu (
		input  alu_op_ID_EX,
		output result, rdat2
	);

	modport regs (
		input  WEN_ID_EX, reg_dest_ID_EX, Rt_ID_EX, Rd_ID_EX,
		input  dREN_ID_EX, dWEN_ID_EX, halt_ID_EX,
		input  enable_EX_MEM, flush_EX_MEM, result, rdat2,
		output dmemaddr_EX_MEM, dmemstore_EX_MEM, result_EX_MEM, WEN_EX_MEM,
		output reg_dest_EX_MEM, Rt_EX_MEM, Rd_EX_MEM, dmemREN, dmemWEN, halt_EX_MEM
	);

	modport mem (
		input dmemaddr_EX_MEM, dmemstore_EX_MEM, result_EX_MEM, WEN_EX_MEM,
		input reg_dest_EX_MEM, Rt_EX_MEM, Rd_EX_MEM, dmemREN, dmemWEN, halt_EX_MEM,
		input mem_commit
	);

endinterface

// File: src/cpu_types_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types and encodings of the MIPS-style integer pipeline.
// Only word accesses and the opcodes listed here are supported.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package cpu_types_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regbits_t;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_LUI = 4'd7
	} aluop_t;

	// selects which instruction field names the writeback register.
	typedef enum logic {
		SEL_RD = 1'b0,
		SEL_RT = 1'b1
	} reg_dest_mux_selection;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// opcode and funct encodings.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ANDI  = 6'h0C;
	localparam logic [5:0] OP_ORI   = 6'h0D;
	localparam logic [5:0] OP_LUI   = 6'h0F;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2B;
	localparam logic [5:0] OP_HALT  = 6'h3F;

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2A;

	typedef struct packed {
		logic [5:0] opcode;
		regbits_t   rs;
		regbits_t   rt;
		regbits_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rtype_t;

	typedef struct packed {
		logic [5:0]  opcode;
		regbits_t    rs;
		regbits_t    rt;
		logic [15:0] imm;
	} itype_t;

	// the same instruction word seen as R-type or as I-type.
	typedef union packed {
		rtype_t r;
		itype_t i;
	} instr_u;

endpackage

// File: src/cpu_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes of the internal data memory.
// DMEM_AW must equal log2 of DMEM_WORDS. Addresses wrap modulo the depth.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// number of 32-bit words in the data memory.
`define DMEM_WORDS 64

// word address width, the byte address uses bits above bit 1.
`define DMEM_AW 6

`endif
